// File: source/lsu_pkg.sv
package lsu_pkg;

  // core word width
  localparam int XLEN = 64;

  typedef enum logic [1:0] {
    LSU_BYTE   = 2'd0,
    LSU_HALF   = 2'd1,
    LSU_WORD   = 2'd2,
    LSU_DOUBLE = 2'd3
  } lsu_width_e;

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // one memory-stage request
  typedef struct packed {
    lsu_op_e         op;
    lsu_width_e      width;
    logic            is_unsigned;
    logic [63:0]     addr;
    logic [XLEN-1:0] wdata;
    logic [4:0]      rd;
  } lsu_req_t;

  // completion report back to the core
  typedef struct packed {
    lsu_op_e         op;
    logic            err;
    logic            misalign;
    logic            wb_en;
    logic [4:0]      rd;
    logic [XLEN-1:0] rdata;
  } lsu_rsp_t;

  // bit 0 enable, bit 1 fault_on_misalign
  typedef struct packed {
    logic fault_on_misalign;
    logic enable;
  } lsu_ctrl_t;

  // single-cycle pulses toward the register block
  typedef struct packed {
    logic        load_done;
    logic        store_done;
    logic        bus_error;
    logic        misalign;
    logic [63:0] fault_addr;
  } lsu_event_t;

endpackage

// File: source/axi_pkg.sv
package axi_pkg;

  // ==============================
  // response codes
  // ==============================
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // ==============================
  // channel payloads
  // ==============================

  // shared by aw and ar
  typedef struct packed {
    logic [63:0] addr;
    logic [2:0]  prot;
  } axi_addr_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
  } axi_w_t;

  typedef struct packed {
    logic [63:0] data;
    axi_resp_e   resp;
  } axi_r_t;

  // write response carries the code only
  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

endpackage

// File: source/axi_chan_buf.sv
`timescale 1ns/1ps

module axi_chan_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  logic     full_d;
  logic     ready_q;
  payload_t data_q;

  // next occupancy, one entry only
  always_comb begin
    full_d = full_q;
    if (in_valid_i && in_ready_o) begin
      full_d = 1'b1;
    end else if (out_ready_i) begin
      full_d = 1'b0;
    end
  end

  // ready registered off the next occupancy, low while in reset
  always_ff @(posedge clk) begin
    if (rst) begin
      full_q  <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      full_q  <= full_d;
      ready_q <= ~full_d;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign in_ready_o  = ready_q;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  // held payload must not move under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> $stable(out_data_o))
    else $error("axi_chan_buf: payload changed while stalled");

endmodule

// File: source/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
  input  logic [lsu_pkg::XLEN-1:0] rdata_i,
  input  logic [2:0]               offset_i,
  input  lsu_pkg::lsu_width_e      width_i,
  input  logic                     unsigned_i,
  output logic [lsu_pkg::XLEN-1:0] data_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] mask;
  logic            sign;

  always_comb begin
    // move the addressed byte down to lane 0
    shifted = rdata_i >> {offset_i, 3'b000};
    case (width_i)
      LSU_BYTE: begin
        mask = {{(XLEN-8){1'b0}}, 8'hff};
        sign = shifted[7];
      end
      LSU_HALF: begin
        mask = {{(XLEN-16){1'b0}}, 16'hffff};
        sign = shifted[15];
      end
      LSU_WORD: begin
        mask = {{(XLEN-32){1'b0}}, 32'hffff_ffff};
        sign = shifted[31];
      end
      default: begin
        mask = {XLEN{1'b1}};
        sign = shifted[XLEN-1];
      end
    endcase
    if (unsigned_i) begin
      sign = 1'b0;
    end
    // upper bits filled with the field's sign or zeros
    data_o = (shifted & mask) | ({XLEN{sign}} & ~mask);
  end

endmodule

// File: source/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
  input  logic [lsu_pkg::XLEN-1:0] wdata_i,
  input  logic [2:0]               offset_i,
  input  lsu_pkg::lsu_width_e      width_i,
  output logic [lsu_pkg::XLEN-1:0] data_o,
  output logic [7:0]               strb_o,
  output logic                     misaligned_o
);

  import lsu_pkg::*;

  logic [7:0] strb_base;

  always_comb begin
    case (width_i)
      LSU_BYTE: begin
        strb_base    = 8'h01;
        misaligned_o = 1'b0;
      end
      LSU_HALF: begin
        strb_base    = 8'h03;
        misaligned_o = offset_i[0];
      end
      LSU_WORD: begin
        strb_base    = 8'h0f;
        misaligned_o = |offset_i[1:0];
      end
      default: begin
        strb_base    = 8'hff;
        misaligned_o = |offset_i;
      end
    endcase
    // lanes past the top of the beat fall off
    strb_o = strb_base << offset_i;
    data_o = wdata_i << {offset_i, 3'b000};
  end

endmodule

// File: source/lsu_engine.sv
`timescale 1ns/1ps

module lsu_engine #(
  parameter int ADDR_W = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  lsu_pkg::lsu_req_t   req_i,
  output logic                rsp_valid_o,
  output lsu_pkg::lsu_rsp_t   rsp_o,
  input  lsu_pkg::lsu_ctrl_t  ctrl_i,
  output lsu_pkg::lsu_event_t event_o,
  output logic                aw_valid_o,
  input  logic                aw_ready_i,
  output axi_pkg::axi_addr_t  aw_o,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  output axi_pkg::axi_w_t     w_o,
  input  logic                b_valid_i,
  output logic                b_ready_o,
  input  axi_pkg::axi_b_t     b_i,
  output logic                ar_valid_o,
  input  logic                ar_ready_i,
  output axi_pkg::axi_addr_t  ar_o,
  input  logic                r_valid_i,
  output logic                r_ready_o,
  input  axi_pkg::axi_r_t     r_i
);

  import lsu_pkg::*;
  import axi_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_AW, S_W, S_B, S_AR, S_R, S_RSP
  } state_e;

  state_e          state_q;
  state_e          state_d;
  lsu_req_t        req_q;
  axi_w_t          w_q;
  logic            err_q;
  logic            mis_q;
  logic [XLEN-1:0] rdata_q;
  logic            accept;
  logic            fault;
  logic [XLEN-1:0] st_data;
  logic [7:0]      st_strb;
  logic            st_misaligned;
  logic [XLEN-1:0] ld_data;
  logic [63:0]     bus_addr;

  // ==============================
  // alignment
  // ==============================
  // request side, so the fault decision is ready at accept
  lsu_store_align u_store_align (
    .wdata_i(req_i.wdata), .offset_i(req_i.addr[2:0]), .width_i(req_i.width),
    .data_o(st_data), .strb_o(st_strb), .misaligned_o(st_misaligned)
  );

  lsu_load_align u_load_align (
    .rdata_i(r_i.data), .offset_i(req_q.addr[2:0]), .width_i(req_q.width),
    .unsigned_i(req_q.is_unsigned), .data_o(ld_data)
  );

  assign accept = req_valid_i && req_ready_o;
  assign fault  = st_misaligned && ctrl_i.fault_on_misalign;

  // ==============================
  // state machine
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          if (fault) begin
            state_d = S_RSP;
          end else if (req_i.op == LSU_STORE) begin
            state_d = S_AW;
          end else begin
            state_d = S_AR;
          end
        end
      end
      S_AW:  if (aw_ready_i) state_d = S_W;
      S_W:   if (w_ready_i) state_d = S_B;
      S_B:   if (b_valid_i) state_d = S_RSP;
      S_AR:  if (ar_ready_i) state_d = S_R;
      S_R:   if (r_valid_i) state_d = S_RSP;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // latched request and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q      <= req_i;
      w_q.data   <= st_data;
      w_q.strb   <= st_strb;
      err_q      <= fault;
      mis_q      <= fault;
      rdata_q    <= '0;
    end
    if (state_q == S_B && b_valid_i) begin
      err_q <= (b_i.resp != OKAY);
    end
    if (state_q == S_R && r_valid_i) begin
      err_q   <= (r_i.resp != OKAY);
      rdata_q <= ld_data;
    end
  end

  // ==============================
  // outputs
  // ==============================
  assign req_ready_o = (state_q == S_IDLE) && ctrl_i.enable;
  assign bus_addr    = 64'(req_q.addr[ADDR_W-1:0]);

  assign aw_valid_o = (state_q == S_AW);
  assign aw_o       = '{addr: bus_addr, prot: 3'b000};
  assign w_valid_o  = (state_q == S_W);
  assign w_o        = w_q;
  assign b_ready_o  = (state_q == S_B);
  assign ar_valid_o = (state_q == S_AR);
  assign ar_o       = '{addr: bus_addr, prot: 3'b000};
  assign r_ready_o  = (state_q == S_R);

  assign rsp_valid_o = (state_q == S_RSP);
  assign rsp_o = '{
    op:       req_q.op,
    err:      err_q,
    misalign: mis_q,
    wb_en:    (req_q.op == LSU_LOAD) && !err_q,
    rd:       req_q.rd,
    rdata:    rdata_q
  };

  // pulses ride on the response cycle
  always_comb begin
    event_o            = '0;
    event_o.load_done  = rsp_valid_o && (req_q.op == LSU_LOAD);
    event_o.store_done = rsp_valid_o && (req_q.op == LSU_STORE);
    event_o.bus_error  = rsp_valid_o && err_q && !mis_q;
    event_o.misalign   = rsp_valid_o && mis_q;
    event_o.fault_addr = bus_addr;
  end

  a_rsp_single: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o |=> !rsp_valid_o)
    else $error("lsu_engine: back-to-back responses");

  a_one_addr: assert property (@(posedge clk) disable iff (rst)
    !(aw_valid_o && ar_valid_o))
    else $error("lsu_engine: aw and ar valid together");

endmodule

// File: source/lsu_csr.sv
`timescale 1ns/1ps

module lsu_csr (
  input  logic                clk,
  input  logic                rst,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [7:0]          paddr_i,
  input  logic [31:0]         pwdata_i,
  output logic [31:0]         prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output lsu_pkg::lsu_ctrl_t  ctrl_o,
  input  lsu_pkg::lsu_event_t event_i
);

  import lsu_pkg::*;

  // ==============================
  // register map
  // ==============================
  localparam logic [7:0] ADDR_CTRL   = 8'h00;
  localparam logic [7:0] ADDR_LOADS  = 8'h04;
  localparam logic [7:0] ADDR_STORES = 8'h08;
  localparam logic [7:0] ADDR_ERRORS = 8'h0c;
  localparam logic [7:0] ADDR_FLT_LO = 8'h10;
  localparam logic [7:0] ADDR_FLT_HI = 8'h14;

  lsu_ctrl_t   ctrl_q;
  logic [31:0] load_cnt_q;
  logic [31:0] store_cnt_q;
  logic [31:0] err_cnt_q;
  logic [63:0] fault_addr_q;
  logic        access;
  logic        wr;
  logic        mapped;

  // access phase of the two-phase transfer
  assign access = psel_i && penable_i;
  assign wr     = access && pwrite_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q       <= '0;
      load_cnt_q   <= '0;
      store_cnt_q  <= '0;
      err_cnt_q    <= '0;
      fault_addr_q <= '0;
    end else begin
      if (wr && paddr_i == ADDR_CTRL) begin
        ctrl_q <= lsu_ctrl_t'(pwdata_i[1:0]);
      end
      // counters clear on a write, else count events
      if (wr && paddr_i == ADDR_LOADS) begin
        load_cnt_q <= '0;
      end else if (event_i.load_done) begin
        load_cnt_q <= load_cnt_q + 32'd1;
      end
      if (wr && paddr_i == ADDR_STORES) begin
        store_cnt_q <= '0;
      end else if (event_i.store_done) begin
        store_cnt_q <= store_cnt_q + 32'd1;
      end
      if (wr && paddr_i == ADDR_ERRORS) begin
        err_cnt_q <= '0;
      end else if (event_i.bus_error || event_i.misalign) begin
        err_cnt_q <= err_cnt_q + 32'd1;
      end
      if (event_i.bus_error || event_i.misalign) begin
        fault_addr_q <= event_i.fault_addr;
      end
    end
  end

  // read mux
  always_comb begin
    mapped   = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      ADDR_CTRL:   prdata_o = 32'(ctrl_q);
      ADDR_LOADS:  prdata_o = load_cnt_q;
      ADDR_STORES: prdata_o = store_cnt_q;
      ADDR_ERRORS: prdata_o = err_cnt_q;
      ADDR_FLT_LO: prdata_o = fault_addr_q[31:0];
      ADDR_FLT_HI: prdata_o = fault_addr_q[63:32];
      default:     mapped = 1'b0;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access && !mapped;
  assign ctrl_o    = ctrl_q;

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int ADDR_W = 32
) (
  input  logic               clk,
  input  logic               rst,
  // core side
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  lsu_pkg::lsu_req_t  req_i,
  output logic               rsp_valid_o,
  output lsu_pkg::lsu_rsp_t  rsp_o,
  // bus side
  output logic               aw_valid_o,
  input  logic               aw_ready_i,
  output axi_pkg::axi_addr_t aw_o,
  output logic               w_valid_o,
  input  logic               w_ready_i,
  output axi_pkg::axi_w_t    w_o,
  input  logic               b_valid_i,
  output logic               b_ready_o,
  input  axi_pkg::axi_b_t    b_i,
  output logic               ar_valid_o,
  input  logic               ar_ready_i,
  output axi_pkg::axi_addr_t ar_o,
  input  logic               r_valid_i,
  output logic               r_ready_o,
  input  axi_pkg::axi_r_t    r_i,
  // apb register port
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [7:0]         paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o
);

  import lsu_pkg::*;
  import axi_pkg::*;

  lsu_ctrl_t  ctrl;
  lsu_event_t evt;

  // engine side of the channel buffers
  logic      e_aw_valid, e_aw_ready, e_w_valid, e_w_ready, e_b_valid, e_b_ready;
  logic      e_ar_valid, e_ar_ready, e_r_valid, e_r_ready;
  axi_addr_t e_aw, e_ar;
  axi_w_t    e_w;
  axi_b_t    e_b;
  axi_r_t    e_r;

  lsu_engine #(.ADDR_W(ADDR_W)) u_engine (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
    .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o), .ctrl_i(ctrl), .event_o(evt),
    .aw_valid_o(e_aw_valid), .aw_ready_i(e_aw_ready), .aw_o(e_aw),
    .w_valid_o(e_w_valid), .w_ready_i(e_w_ready), .w_o(e_w),
    .b_valid_i(e_b_valid), .b_ready_o(e_b_ready), .b_i(e_b),
    .ar_valid_o(e_ar_valid), .ar_ready_i(e_ar_ready), .ar_o(e_ar),
    .r_valid_i(e_r_valid), .r_ready_o(e_r_ready), .r_i(e_r)
  );

  lsu_csr u_csr (
    .clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i),
    .pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .ctrl_o(ctrl), .event_i(evt)
  );

  // ==============================
  // channel buffers
  // ==============================
  axi_chan_buf #(.payload_t(axi_addr_t)) u_aw_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(e_aw_valid), .in_ready_o(e_aw_ready), .in_data_i(e_aw),
    .out_valid_o(aw_valid_o), .out_ready_i(aw_ready_i), .out_data_o(aw_o)
  );

  axi_chan_buf #(.payload_t(axi_w_t)) u_w_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(e_w_valid), .in_ready_o(e_w_ready), .in_data_i(e_w),
    .out_valid_o(w_valid_o), .out_ready_i(w_ready_i), .out_data_o(w_o)
  );

  // response channels run bus to engine
  axi_chan_buf #(.payload_t(axi_b_t)) u_b_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(b_valid_i), .in_ready_o(b_ready_o), .in_data_i(b_i),
    .out_valid_o(e_b_valid), .out_ready_i(e_b_ready), .out_data_o(e_b)
  );

  axi_chan_buf #(.payload_t(axi_addr_t)) u_ar_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(e_ar_valid), .in_ready_o(e_ar_ready), .in_data_i(e_ar),
    .out_valid_o(ar_valid_o), .out_ready_i(ar_ready_i), .out_data_o(ar_o)
  );

  axi_chan_buf #(.payload_t(axi_r_t)) u_r_buf (
    .clk(clk), .rst(rst),
    .in_valid_i(r_valid_i), .in_ready_o(r_ready_o), .in_data_i(r_i),
    .out_valid_o(e_r_valid), .out_ready_i(e_r_ready), .out_data_o(e_r)
  );

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
  input  logic               clk,
  input  logic               rst,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  axi_pkg::axi_addr_t aw_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  input  axi_pkg::axi_w_t    w_i,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  output axi_pkg::axi_b_t    b_o,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  axi_pkg::axi_addr_t ar_i,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output axi_pkg::axi_r_t    r_o
);

  import axi_pkg::*;

  logic [63:0] mem [0:511];
  logic [63:0] waddr_q;
  logic        have_aw;
  logic        b_pend;
  logic        have_ar;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  integer      seed;

  initial begin
    seed = 84;
    for (int i = 0; i < 512; i++) begin
      mem[i] = '0;
    end
  end

  assign aw_hs = aw_valid_i && aw_ready_o && !have_aw;
  assign w_hs  = w_valid_i && w_ready_o && have_aw && !b_pend;
  assign ar_hs = ar_valid_i && ar_ready_o && !have_ar;

  // ==============================
  // write side
  // ==============================
  always @(posedge clk) begin
    if (rst) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      b_o        <= '0;
      have_aw    <= 1'b0;
      b_pend     <= 1'b0;
    end else begin
      // ready stalls at random, about one cycle in four
      aw_ready_o <= !have_aw && !aw_hs && (($random(seed) & 3) != 0);
      w_ready_o  <= have_aw && !b_pend && !w_hs && (($random(seed) & 3) != 0);
      if (aw_hs) begin
        have_aw <= 1'b1;
        waddr_q <= aw_i.addr;
      end
      if (w_hs) begin
        b_pend    <= 1'b1;
        b_valid_o <= 1'b1;
        // bit 12 marks the error region
        if (waddr_q[12]) begin
          b_o.resp <= SLVERR;
        end else begin
          b_o.resp <= OKAY;
          for (int b = 0; b < 8; b++) begin
            if (w_i.strb[b]) begin
              mem[waddr_q[11:3]][8*b +: 8] <= w_i.data[8*b +: 8];
            end
          end
        end
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        b_pend    <= 1'b0;
        have_aw   <= 1'b0;
      end
    end
  end

  // ==============================
  // read side
  // ==============================
  always @(posedge clk) begin
    if (rst) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_o        <= '0;
      have_ar    <= 1'b0;
    end else begin
      ar_ready_o <= !have_ar && !ar_hs && (($random(seed) & 3) != 0);
      if (ar_hs) begin
        have_ar   <= 1'b1;
        r_valid_o <= 1'b1;
        if (ar_i.addr[12]) begin
          r_o.data <= '0;
          r_o.resp <= SLVERR;
        end else begin
          r_o.data <= mem[ar_i.addr[11:3]];
          r_o.resp <= OKAY;
        end
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        have_ar   <= 1'b0;
      end
    end
  end

endmodule

// File: test/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  import lsu_pkg::*;
  import axi_pkg::*;

  typedef struct {
    string      name;
    lsu_op_e    op;
    lsu_width_e width;
    logic       uns;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic       fom;
    logic       exp_err;
    logic       exp_mis;
  } row_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic req_valid = 1'b0;
  logic req_ready;
  lsu_req_t req = '0;
  logic rsp_valid;
  lsu_rsp_t rsp;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  axi_addr_t aw, ar;
  axi_w_t w;
  axi_b_t b;
  axi_r_t r;
  logic psel = 1'b0;
  logic penable = 1'b0;
  logic pwrite = 1'b0;
  logic [7:0] paddr = '0;
  logic [31:0] pwdata = '0;
  logic [31:0] prdata;
  logic pready, pslverr;

  row_t table_q[$];
  logic [7:0] mirror [0:4095];
  int cycles = 0;
  int limit = 1000000;

  always #4 clk = ~clk;

  lsu_top #(.ADDR_W(32)) dut_i (
    .clk(clk), .rst(rst),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_o(aw),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_o(w),
    .b_valid_i(b_valid), .b_ready_o(b_ready), .b_i(b),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_o(ar),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_i(r),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  axi_mem_model u_mem (
    .clk(clk), .rst(rst),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_i(aw),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_i(w),
    .b_valid_o(b_valid), .b_ready_i(b_ready), .b_o(b),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_i(ar),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_o(r)
  );

  // run limit scales with the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: no completion within %0d cycles", limit);
      $display("sim failed");
      $fatal(1);
    end
  end

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    assert (exp === act)
      else begin
        $display("Mismatch %s expected %h actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1);
      end
  endtask

  task automatic add_row(input string name, input lsu_op_e op, input lsu_width_e width,
                         input logic uns, input logic [63:0] addr, input logic [63:0] wdata,
                         input logic fom, input logic exp_err, input logic exp_mis);
    row_t row;
    row = '{name, op, width, uns, addr, wdata, fom, exp_err, exp_mis};
    table_q.push_back(row);
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    assert (pready)
      else begin
        $display("register write at %h was not ready", addr);
        $display("sim failed");
        $fatal(1);
      end
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    psel = 1'b1;
    paddr = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    data = prdata;
    assert (pready && !pslverr)
      else begin
        $display("register read at %h was not ready or returned a slave error", addr);
        $display("sim failed");
        $fatal(1);
      end
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // holds the offered request until accepted, then waits for the response pulse
  task automatic complete_request(output lsu_rsp_t rs);
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    while (!rsp_valid) begin
      @(posedge clk);
      #1;
    end
    rs = rsp;
  endtask

  task automatic send_request(input lsu_req_t rq, output lsu_rsp_t rs);
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req = rq;
    complete_request(rs);
  endtask

  // ==============================
  // byte mirror of memory
  // ==============================
  task automatic apply_store(input logic [63:0] addr, input lsu_width_e width,
                             input logic [63:0] data);
    int n;
    int off;
    n = 1 << width;
    off = addr[2:0];
    for (int i = 0; i < n; i++) begin
      if (off + i < 8) begin
        mirror[{addr[11:3], 3'b000} + off + i] = data[8*i +: 8];
      end
    end
  endtask

  function automatic logic [63:0] expect_load(input logic [63:0] addr,
                                              input lsu_width_e width, input logic uns);
    int n;
    int off;
    logic [63:0] val;
    n = 1 << width;
    off = addr[2:0];
    val = '0;
    for (int i = 0; i < n; i++) begin
      if (off + i < 8) begin
        val[8*i +: 8] = mirror[{addr[11:3], 3'b000} + off + i];
      end
    end
    // replicate the field's top bit for signed loads
    if (!uns && n < 8 && val[8*n-1]) begin
      for (int k = 8 * n; k < 64; k++) begin
        val[k] = 1'b1;
      end
    end
    return val;
  endfunction

  initial begin
    lsu_req_t rq;
    lsu_rsp_t rs;
    row_t row;
    logic [63:0] exp_data;
    logic [63:0] last_fault;
    logic [31:0] rd_val;
    logic cur_fom;
    int n_loads;
    int n_stores;
    int n_errs;

    for (int i = 0; i < 4096; i++) begin
      mirror[i] = 8'h00;
    end
    add_row("sd_base", LSU_STORE, LSU_DOUBLE, 0, 64'h100, 64'h0123_4567_89ab_cdef, 0, 0, 0);
    add_row("sb_off3", LSU_STORE, LSU_BYTE, 0, 64'h103, 64'ha5, 0, 0, 0);
    add_row("sh_off6", LSU_STORE, LSU_HALF, 0, 64'h106, 64'hbeef, 0, 0, 0);
    add_row("sw_off0", LSU_STORE, LSU_WORD, 0, 64'h108, 64'hdead_beef, 0, 0, 0);
    add_row("sb_off7", LSU_STORE, LSU_BYTE, 0, 64'h10f, 64'h80, 0, 0, 0);
    add_row("ld_100", LSU_LOAD, LSU_DOUBLE, 0, 64'h100, 0, 0, 0, 0);
    add_row("ld_108", LSU_LOAD, LSU_DOUBLE, 0, 64'h108, 0, 0, 0, 0);
    add_row("lb_103", LSU_LOAD, LSU_BYTE, 0, 64'h103, 0, 0, 0, 0);
    add_row("lbu_103", LSU_LOAD, LSU_BYTE, 1, 64'h103, 0, 0, 0, 0);
    add_row("lh_106", LSU_LOAD, LSU_HALF, 0, 64'h106, 0, 0, 0, 0);
    add_row("lhu_106", LSU_LOAD, LSU_HALF, 1, 64'h106, 0, 0, 0, 0);
    add_row("lw_108", LSU_LOAD, LSU_WORD, 0, 64'h108, 0, 0, 0, 0);
    add_row("lwu_108", LSU_LOAD, LSU_WORD, 1, 64'h108, 0, 0, 0, 0);
    add_row("lb_10f", LSU_LOAD, LSU_BYTE, 0, 64'h10f, 0, 0, 0, 0);
    add_row("sw_mis_fault", LSU_STORE, LSU_WORD, 0, 64'h202, 64'h5566_7788, 1, 1, 1);
    add_row("lw_mis_fault", LSU_LOAD, LSU_WORD, 0, 64'h201, 0, 1, 1, 1);
    add_row("ld_200_clean", LSU_LOAD, LSU_DOUBLE, 0, 64'h200, 0, 1, 0, 0);
    add_row("sw_mis_pass", LSU_STORE, LSU_WORD, 0, 64'h202, 64'h1122_3344, 0, 0, 0);
    add_row("lw_mis_pass", LSU_LOAD, LSU_WORD, 0, 64'h202, 0, 0, 0, 0);
    add_row("ld_200_merged", LSU_LOAD, LSU_DOUBLE, 0, 64'h200, 0, 0, 0, 0);
    add_row("sd_err_region", LSU_STORE, LSU_DOUBLE, 0, 64'h1040, 64'hcafe, 0, 1, 0);
    add_row("ld_err_region", LSU_LOAD, LSU_DOUBLE, 0, 64'h1048, 0, 0, 1, 0);
    limit = table_q.size() * 64 + 200;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    apb_write(8'h00, 32'h1);
    cur_fom = 1'b0;
    n_loads = 0;
    n_stores = 0;
    n_errs = 0;
    last_fault = '0;

    // ==============================
    // table
    // ==============================
    for (int i = 0; i < table_q.size(); i++) begin
      row = table_q[i];
      if (row.fom != cur_fom) begin
        apb_write(8'h00, {30'd0, row.fom, 1'b1});
        cur_fom = row.fom;
      end
      rq = '{op: row.op, width: row.width, is_unsigned: row.uns, addr: row.addr,
             wdata: row.wdata, rd: i[4:0]};
      exp_data = '0;
      if (row.op == LSU_LOAD && !row.exp_err) begin
        exp_data = expect_load(row.addr, row.width, row.uns);
      end
      send_request(rq, rs);
      compare_value({row.name, " op"}, row.op, rs.op);
      compare_value({row.name, " err"}, row.exp_err, rs.err);
      compare_value({row.name, " misalign"}, row.exp_mis, rs.misalign);
      compare_value({row.name, " wb_en"}, row.op == LSU_LOAD && !row.exp_err, rs.wb_en);
      compare_value({row.name, " rd"}, i[4:0], rs.rd);
      compare_value({row.name, " data"}, exp_data, rs.rdata);
      if (row.op == LSU_STORE && !row.exp_err) begin
        apply_store(row.addr, row.width, row.wdata);
      end
      if (row.op == LSU_LOAD) begin
        n_loads++;
      end else begin
        n_stores++;
      end
      if (row.exp_err) begin
        n_errs++;
        last_fault = {32'd0, row.addr[31:0]};
      end
    end

    apb_read(8'h04, rd_val);
    compare_value("load count", n_loads, rd_val);
    apb_read(8'h08, rd_val);
    compare_value("store count", n_stores, rd_val);
    apb_read(8'h0c, rd_val);
    compare_value("error count", n_errs, rd_val);
    apb_read(8'h10, rd_val);
    compare_value("fault addr low", last_fault[31:0], rd_val);
    apb_read(8'h14, rd_val);
    compare_value("fault addr high", last_fault[63:32], rd_val);

    // ==============================
    // enable gating
    // ==============================
    apb_write(8'h00, 32'h0);
    rq = '{op: LSU_LOAD, width: LSU_DOUBLE, is_unsigned: 1'b0, addr: 64'h100,
           wdata: '0, rd: 5'd7};
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req = rq;
    repeat (20) begin
      assert (!req_ready)
        else begin
          $display("request accepted while the unit was disabled");
          $display("sim failed");
          $fatal(1);
        end
      @(posedge clk);
      #1;
    end
    // the request stays offered across the enable write
    apb_write(8'h00, 32'h1);
    complete_request(rs);
    compare_value("enable load op", LSU_LOAD, rs.op);
    compare_value("enable load data", expect_load(64'h100, LSU_DOUBLE, 1'b0), rs.rdata);
    compare_value("enable load rd", 5'd7, rs.rd);
    compare_value("enable load wb_en", 1'b1, rs.wb_en);
    compare_value("enable load err", 1'b0, rs.err);

    $display("sim passed");
    $finish;
  end

endmodule

// File: verilog.f
source/lsu_pkg.sv
source/axi_pkg.sv
source/axi_chan_buf.sv
source/lsu_load_align.sv
source/lsu_store_align.sv
source/lsu_engine.sv
source/lsu_csr.sv
source/lsu_top.sv
test/axi_mem_model.sv
test/tb_lsu.sv
